// File: source/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN = 32;
    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_W = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_B = 3'b000;
    localparam logic [2:0] F3_W = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_ADD = 3'b000;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_ADDI,
        OP_LB,
        OP_LBU,
        OP_LW,
        OP_SB,
        OP_SW
    } mem_op_e;

    // I-type layout shared by loads and ADDI.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } load_fmt_t;

    // S-type layout with the immediate split around rs1 and rs2.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } store_fmt_t;

    typedef union packed {
        load_fmt_t  load;
        store_fmt_t store;
    } inst_u;

    typedef struct packed {
        inst_u           inst;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } issue_t;

    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        logic [XLEN-1:0] inst;
    } ex_mem_t;

    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] value;
    } mem_wb_t;

    typedef struct packed {
        logic            write_enable;
        logic [4:0]      dest;
        logic [XLEN-1:0] data;
    } reg_fwd_t;

endpackage

// File: source/lsu_issue.sv
`timescale 1ns/100ps

module lsu_issue (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_req,
    output logic             issue_ack,
    input  lsu_pkg::issue_t  issue,
    output logic             push,
    output lsu_pkg::ex_mem_t push_data,
    input  logic             full
);
    import lsu_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_ACK
    } state_e;

    state_e          state;
    logic            start;
    logic            is_store;
    logic [XLEN-1:0] imm;
    mem_op_e         op;

    // Stores carry their immediate split in two, everything else uses the I-type field.
    assign is_store = issue.inst.store.opcode == OPC_STORE;

    always_comb begin
        if (is_store) begin
            imm = {{20{issue.inst.store.imm_hi[6]}}, issue.inst.store.imm_hi,
                   issue.inst.store.imm_lo};
        end else begin
            imm = {{20{issue.inst.load.imm[11]}}, issue.inst.load.imm};
        end
    end

    always_comb begin
        op = OP_NONE;
        case (issue.inst.load.opcode)
            OPC_LOAD: begin
                case (issue.inst.load.funct3)
                    F3_B:    op = OP_LB;
                    F3_BU:   op = OP_LBU;
                    F3_W:    op = OP_LW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (issue.inst.store.funct3)
                    F3_B:    op = OP_SB;
                    F3_W:    op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                if (issue.inst.load.funct3 == F3_ADD) begin
                    op = OP_ADDI;
                end
            end
            default: op = OP_NONE;
        endcase
    end

    // A new request is only taken while the queue has room.
    assign start = (state == S_IDLE) && issue_req && !full;
    assign issue_ack = state == S_ACK;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            push <= 1'b0;
        end else begin
            push <= start;
            case (state)
                S_IDLE: if (start) state <= S_ACK;
                S_ACK: if (!issue_req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            push_data.op <= op;
            push_data.alu_result <= issue.rs1_val + imm;
            push_data.store_data <= issue.rs2_val;
            push_data.rd <= issue.inst.load.rd;
            push_data.inst <= issue.inst;
        end
    end

endmodule

// File: source/ex_mem_queue.sv
`timescale 1ns/100ps

module ex_mem_queue (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  lsu_pkg::ex_mem_t push_data,
    output logic             full,
    input  logic             pop,
    output lsu_pkg::ex_mem_t head,
    output logic             empty
);
    import lsu_pkg::*;

    ex_mem_t                entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   do_push;
    logic                   do_pop;

    assign full = count == QUEUE_DEPTH;
    assign empty = count == 0;
    assign head = entries[rd_ptr];

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // The pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

// File: source/mem_access_stage.sv
`timescale 1ns/100ps

module mem_access_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  lsu_pkg::ex_mem_t               head,
    input  logic                           empty,
    output logic                           pop,
    output logic                           dbus_req,
    output logic                           dbus_we,
    output logic [lsu_pkg::MEM_ADDR_W-1:0] dbus_addr,
    output logic [lsu_pkg::XLEN-1:0]       dbus_wdata,
    output logic [3:0]                     dbus_strb,
    input  logic                           dbus_ack,
    input  logic [lsu_pkg::XLEN-1:0]       dbus_rdata,
    output logic                           wb_valid,
    output lsu_pkg::mem_wb_t               wb,
    output lsu_pkg::reg_fwd_t              fwd,
    input  logic                           wb_ready
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_EXEC,
        S_REQ,
        S_RELEASE,
        S_DONE
    } state_e;

    state_e          state;
    ex_mem_t         rec;
    logic [XLEN-1:0] load_word;
    logic [XLEN-1:0] load_value;
    logic [7:0]      load_byte;
    logic            is_load;
    logic            is_store;

    assign is_load = rec.op inside {OP_LB, OP_LBU, OP_LW};
    assign is_store = rec.op inside {OP_SB, OP_SW};

    // Only one record is in the stage, the next pop waits for the writeback.
    assign pop = (state == S_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (!empty) state <= S_EXEC;
                S_EXEC: state <= (is_load || is_store) ? S_REQ : S_DONE;
                S_REQ: if (dbus_ack) state <= S_RELEASE;
                S_RELEASE: if (!dbus_ack) state <= S_DONE;
                S_DONE: if (wb_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rec <= head;
        end
        if (state == S_REQ && dbus_ack) begin
            load_word <= dbus_rdata;
        end
    end

    assign dbus_req = state == S_REQ;
    assign dbus_we = is_store;
    assign dbus_addr = rec.alu_result[MEM_ADDR_W+1:2];

    // A byte store is copied to every lane and the strobe picks the one that lands.
    always_comb begin
        dbus_wdata = rec.store_data;
        dbus_strb = 4'b0000;
        if (rec.op == OP_SB) begin
            dbus_wdata = {4{rec.store_data[7:0]}};
            dbus_strb = 4'b0001 << rec.alu_result[1:0];
        end else if (rec.op == OP_SW) begin
            dbus_strb = 4'b1111;
        end
    end

    assign load_byte = load_word[{rec.alu_result[1:0], 3'b000} +: 8];

    always_comb begin
        case (rec.op)
            OP_LB:   load_value = {{24{load_byte[7]}}, load_byte};
            OP_LBU:  load_value = {24'b0, load_byte};
            OP_LW:   load_value = load_word;
            default: load_value = rec.alu_result;
        endcase
    end

    assign wb_valid = state == S_DONE;

    always_comb begin
        wb.op = rec.op;
        wb.inst = rec.inst;
        wb.value = load_value;
        fwd.write_enable = is_load || (rec.op == OP_ADDI && rec.rd != 5'd0);
        fwd.dest = rec.rd;
        fwd.data = load_value;
    end

endmodule

// File: source/data_memory.sv
`timescale 1ns/100ps

module data_memory (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dbus_req,
    input  logic                           dbus_we,
    input  logic [lsu_pkg::MEM_ADDR_W-1:0] dbus_addr,
    input  logic [lsu_pkg::XLEN-1:0]       dbus_wdata,
    input  logic [3:0]                     dbus_strb,
    output logic                           dbus_ack,
    output logic [lsu_pkg::XLEN-1:0]       dbus_rdata
);
    import lsu_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic            start;

    // The access happens once, on the edge where a new request meets a low ack.
    assign start = dbus_req && !dbus_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            dbus_ack <= 1'b0;
        end else if (start) begin
            dbus_ack <= 1'b1;
        end else if (!dbus_req && dbus_ack) begin
            dbus_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dbus_rdata <= mem[dbus_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (start && dbus_we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dbus_strb[lane]) begin
                    mem[dbus_addr][lane*8 +: 8] <= dbus_wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_req,
    output logic              issue_ack,
    input  lsu_pkg::issue_t   issue,
    output logic              wb_valid,
    output lsu_pkg::mem_wb_t  wb,
    output lsu_pkg::reg_fwd_t fwd,
    input  logic              wb_ready
);
    import lsu_pkg::*;

    logic                  push;
    ex_mem_t               push_data;
    logic                  full;
    logic                  pop;
    ex_mem_t               head;
    logic                  empty;
    logic                  dbus_req;
    logic                  dbus_we;
    logic [MEM_ADDR_W-1:0] dbus_addr;
    logic [XLEN-1:0]       dbus_wdata;
    logic [3:0]            dbus_strb;
    logic                  dbus_ack;
    logic [XLEN-1:0]       dbus_rdata;

    lsu_issue issue_i (
        .clk, .reset, .issue_req, .issue_ack, .issue, .push, .push_data, .full
    );

    ex_mem_queue queue_i (
        .clk, .reset, .push, .push_data, .full, .pop, .head, .empty
    );

    mem_access_stage stage_i (
        .clk, .reset, .head, .empty, .pop,
        .dbus_req, .dbus_we, .dbus_addr, .dbus_wdata, .dbus_strb,
        .dbus_ack, .dbus_rdata,
        .wb_valid, .wb, .fwd, .wb_ready
    );

    data_memory memory_i (
        .clk, .reset,
        .dbus_req, .dbus_we, .dbus_addr, .dbus_wdata, .dbus_strb,
        .dbus_ack, .dbus_rdata
    );

endmodule

// File: verification/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int N_INIT = MEM_WORDS;
    localparam int N_LOADS = 300;
    localparam int N_MIX = 400;
    localparam int N_TOTAL = N_INIT + N_LOADS + N_MIX;
    localparam int CYCLE_LIMIT = 40 * N_TOTAL + 200;
    localparam logic [7:0] WINDOW_BASE = 8'h40;

    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] value;
        logic            has_value;
        logic            write_enable;
        logic [4:0]      dest;
    } expect_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     issue_req;
    logic     issue_ack;
    issue_t   issue;
    logic     wb_valid;
    mem_wb_t  wb;
    reg_fwd_t fwd;
    logic     wb_ready;

    logic [XLEN-1:0] shadow [MEM_WORDS];
    expect_t         expected [$];
    int              cycles;

    lsu_top lsu_top_i (
        .clk, .reset, .issue_req, .issue_ack, .issue, .wb_valid, .wb, .fwd, .wb_ready
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("** Error: %s is %h, expected %h", name, got, want);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Half of the addresses land in a small window so stores and loads hit the same words.
    function automatic logic [9:0] pick_addr();
        logic [7:0] word;
        if ($urandom_range(0, 1) == 0) begin
            word = WINDOW_BASE + 8'($urandom_range(0, 15));
        end else begin
            word = 8'($urandom_range(0, MEM_WORDS - 1));
        end
        return {word, 2'($urandom_range(0, 3))};
    endfunction

    // Called on a falling edge, returns on a falling edge once issue_ack is low again.
    task automatic send(input issue_t req, input expect_t exp);
        expected.push_back(exp);
        issue = req;
        issue_req = 1'b1;
        do @(negedge clk); while (!issue_ack);
        issue_req = 1'b0;
        do @(negedge clk); while (issue_ack);
    endtask

    task automatic store_mem(input logic is_byte, input logic [9:0] addr,
                             input logic [XLEN-1:0] data);
        issue_t      req;
        expect_t     exp;
        logic [11:0] imm;
        imm = 12'($urandom);
        req.inst.store.opcode = OPC_STORE;
        req.inst.store.funct3 = is_byte ? F3_B : F3_W;
        req.inst.store.imm_lo = imm[4:0];
        req.inst.store.imm_hi = imm[11:5];
        req.inst.store.rs1 = 5'($urandom);
        req.inst.store.rs2 = 5'($urandom);
        req.rs1_val = {22'b0, addr} - sext12(imm);
        req.rs2_val = data;
        exp = '0;
        exp.op = is_byte ? OP_SB : OP_SW;
        exp.inst = req.inst;
        if (is_byte) begin
            shadow[addr[9:2]][addr[1:0]*8 +: 8] = data[7:0];
        end else begin
            shadow[addr[9:2]] = data;
        end
        send(req, exp);
    endtask

    task automatic load_mem(input mem_op_e op, input logic [9:0] addr);
        issue_t      req;
        expect_t     exp;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [7:0]  lane;
        imm = 12'($urandom);
        rd = 5'($urandom);
        req.inst.load.opcode = OPC_LOAD;
        req.inst.load.funct3 = (op == OP_LW) ? F3_W : (op == OP_LB) ? F3_B : F3_BU;
        req.inst.load.imm = imm;
        req.inst.load.rs1 = 5'($urandom);
        req.inst.load.rd = rd;
        req.rs1_val = {22'b0, addr} - sext12(imm);
        req.rs2_val = $urandom;
        lane = shadow[addr[9:2]][addr[1:0]*8 +: 8];
        exp = '0;
        exp.op = op;
        exp.inst = req.inst;
        exp.has_value = 1'b1;
        exp.write_enable = 1'b1;
        exp.dest = rd;
        case (op)
            OP_LB:   exp.value = {{24{lane[7]}}, lane};
            OP_LBU:  exp.value = {24'b0, lane};
            default: exp.value = shadow[addr[9:2]];
        endcase
        send(req, exp);
    endtask

    task automatic add_imm();
        issue_t      req;
        expect_t     exp;
        logic [11:0] imm;
        logic [4:0]  rd;
        imm = 12'($urandom);
        rd = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
        req.inst.load.opcode = OPC_OP_IMM;
        req.inst.load.funct3 = F3_ADD;
        req.inst.load.imm = imm;
        req.inst.load.rs1 = 5'($urandom);
        req.inst.load.rd = rd;
        req.rs1_val = $urandom;
        req.rs2_val = $urandom;
        exp = '0;
        exp.op = OP_ADDI;
        exp.inst = req.inst;
        exp.value = req.rs1_val + sext12(imm);
        exp.has_value = 1'b1;
        exp.write_enable = rd != 5'd0;
        exp.dest = rd;
        send(req, exp);
    endtask

    task automatic no_op();
        issue_t     req;
        expect_t    exp;
        logic [6:0] opc;
        opc = 7'($urandom);
        if (opc == OPC_LOAD || opc == OPC_STORE || opc == OPC_OP_IMM) begin
            opc = 7'b0110011;
        end
        req.inst = $urandom;
        req.inst.load.opcode = opc;
        req.rs1_val = $urandom;
        req.rs2_val = $urandom;
        exp = '0;
        exp.op = OP_NONE;
        exp.inst = req.inst;
        send(req, exp);
    endtask

    task automatic take_result();
        expect_t exp;
        if (expected.size() == 0) begin
            $display("A result came out while no instruction was outstanding.");
            $display("test failed");
            $fatal(1);
        end
        exp = expected.pop_front();
        check_value("wb.op", wb.op, exp.op);
        check_value("wb.inst", wb.inst, exp.inst);
        if (exp.has_value) begin
            check_value("wb.value", wb.value, exp.value);
            check_value("fwd.data", fwd.data, exp.value);
        end
        check_value("fwd.write_enable", fwd.write_enable, exp.write_enable);
        if (exp.write_enable) begin
            check_value("fwd.dest", fwd.dest, exp.dest);
        end
    endtask

    // Result side. wb_ready drops for random stretches, and a record counts as taken
    // when wb_valid meets the ready value set on this falling edge.
    initial begin
        int hold;
        wb_ready = 1'b0;
        hold = 0;
        forever begin
            @(negedge clk);
            if (hold > 0) begin
                wb_ready = 1'b0;
                hold--;
            end else if ($urandom_range(0, 7) == 0) begin
                wb_ready = 1'b0;
                hold = $urandom_range(1, 30) - 1;
            end else begin
                wb_ready = 1'b1;
            end
            if (wb_valid && wb_ready) begin
                take_result();
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
        $display("test failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(8));
        reset = 1'b1;
        issue_req = 1'b0;
        issue = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow[w] = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (int w = 0; w < N_INIT; w++) begin
            store_mem(1'b0, {8'(w), 2'($urandom_range(0, 3))}, $urandom);
        end
        for (int i = 0; i < N_LOADS; i++) begin
            load_mem(OP_LW, pick_addr());
        end
        for (int i = 0; i < N_MIX; i++) begin
            case ($urandom_range(0, 6))
                0: load_mem(OP_LW, pick_addr());
                1: load_mem(OP_LB, pick_addr());
                2: load_mem(OP_LBU, pick_addr());
                3: store_mem(1'b0, pick_addr(), $urandom);
                4: store_mem(1'b1, pick_addr(), $urandom);
                5: add_imm();
                default: no_op();
            endcase
        end

        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // A few idle cycles so a repeated result would still be caught.
        repeat (20) @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

// File: compile.f
source/lsu_pkg.sv
source/lsu_issue.sv
source/ex_mem_queue.sv
source/mem_access_stage.sv
source/data_memory.sv
source/lsu_top.sv
verification/lsu_tb.sv
